// File: source/imem_pkg.sv
/*
  Shared widths, depths and types of the instruction fetch controller.
  Queue depths must be powers of two because the pointers wrap on overflow.
  PARCEL_ALMOST_FULL leaves room for two queued PCs and one read in flight.
*/

package imem_pkg;

  //////////////////////////////
  // Widths

  localparam int ADDR_W    = 32;
  localparam int WORD_W    = 32;
  localparam int HALF_BITS = 16;                  // One compressed parcel
  localparam int HALVES    = WORD_W / HALF_BITS;

  //////////////////////////////
  // Attribute regions

  localparam int PMA_CNT = 4;

  //////////////////////////////
  // Queue sizing

  localparam int PC_QUEUE_DEPTH = 2;
  localparam int PC_PTR_W       = $clog2(PC_QUEUE_DEPTH);
  localparam int PC_CNT_W       = $clog2(PC_QUEUE_DEPTH + 1);

  localparam int PARCEL_QUEUE_DEPTH = 8;
  localparam int PQ_PTR_W           = $clog2(PARCEL_QUEUE_DEPTH);
  localparam int PQ_CNT_W           = $clog2(PARCEL_QUEUE_DEPTH + 1);

  // Fill level where new PCs are refused
  localparam int PARCEL_ALMOST_FULL = 5;
  // Fill level where no new bus read may start
  localparam int PARCEL_ROOM_LIMIT  = PARCEL_ALMOST_FULL + 2;

  //////////////////////////////
  // Types

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [HALVES-1:0] parcel_valid_t;   // One flag per half

  // Valid patterns of a parcel queue entry
  localparam parcel_valid_t VALID_BOTH = 2'b11;
  localparam parcel_valid_t VALID_LOW  = 2'b01;   // PC on upper half of a word

  // Fetch sequencer
  typedef enum logic [1:0] {
    IDLE,    // Waiting for a PC at the queue head
    BUS,     // Wishbone read in progress
    DRAIN    // Read flushed, waiting for the slave to finish
  } fetch_state_e;

endpackage

// File: source/imem_pc_queue.sv
/*
  Two-entry queue of fetch addresses from the CPU.
  A PC pushed together with a flush is kept as the new head.
  The caller must not push while full_o is high.
*/

`timescale 1ns/100ps

module imem_pc_queue import imem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  flush_i,
  input  logic  push_i,
  input  addr_t pc_i,
  input  logic  pop_i,
  output logic  head_valid_o,
  output addr_t head_pc_o,
  output logic  full_o
);

  addr_t               pc_mem [PC_QUEUE_DEPTH];
  logic [PC_PTR_W-1:0] wr_ptr;
  logic [PC_PTR_W-1:0] rd_ptr;
  logic [PC_PTR_W-1:0] wr_sel;
  logic [PC_CNT_W-1:0] count;
  logic                do_pop;

  assign head_valid_o = (count != '0);
  assign full_o       = (count == PC_CNT_W'(PC_QUEUE_DEPTH));
  assign head_pc_o    = pc_mem[rd_ptr];
  assign do_pop       = pop_i && head_valid_o;
  assign wr_sel       = flush_i ? '0 : wr_ptr;   // Flush restarts at slot 0

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      rd_ptr <= '0;
      wr_ptr <= push_i ? PC_PTR_W'(1) : '0;
      count  <= push_i ? PC_CNT_W'(1) : '0;
    end else begin
      if (push_i) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) pc_mem[wr_sel] <= pc_i;
  end

  // The top level must hold off the CPU before this queue overflows
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i && !flush_i |-> !full_o)
    else $error("PC queue push while full");

endmodule

// File: source/imem_pma_check.sv
/*
  Executable check of a fetch address against the attribute regions.
  Limits are exclusive and expected in ascending order; the lowest
  matching region wins. An address above every limit is a fault.
*/

`timescale 1ns/100ps

module imem_pma_check import imem_pkg::*; (
  input  addr_t               pc_i,
  input  addr_t [PMA_CNT-1:0] pma_limit_i,
  input  logic  [PMA_CNT-1:0] pma_exec_i,
  output logic                fault_o
);

  logic [PMA_CNT-1:0] below;   // PC under each region limit
  logic [PMA_CNT-1:0] first;   // One-hot first matching region
  logic               hit;
  logic               exec;

  //////////////////////////////
  // Per-region compare

  always_comb begin
    for (int i = 0; i < PMA_CNT; i++) begin
      below[i] = (pc_i < pma_limit_i[i]);
    end
  end

  //////////////////////////////
  // Priority pick

  always_comb begin : pick
    logic taken;
    taken = 1'b0;
    for (int i = 0; i < PMA_CNT; i++) begin
      first[i] = below[i] && !taken;   // Only the lowest region survives
      taken    = taken || below[i];
    end
  end

  assign hit  = |below;
  assign exec = |(first & pma_exec_i);

  // Unmapped or non-executable
  assign fault_o = !hit || !exec;

endmodule

// File: source/imem_wb_fetch.sv
/*
  Fetch sequencer between the PC queue and the parcel queue.
  Misaligned and PMA-faulting PCs are answered without a bus cycle.
  One Wishbone classic read at a time; a flushed read runs to its end
  on the bus and its data is dropped.
*/

`timescale 1ns/100ps

module imem_wb_fetch import imem_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          flush_i,
  input  logic          head_valid_i,
  input  addr_t         head_pc_i,
  input  logic          pma_fault_i,
  input  logic          room_i,
  output logic          pop_o,
  output logic          wb_cyc_o,
  output logic          wb_stb_o,
  output addr_t         wb_adr_o,
  input  word_t         wb_dat_i,
  input  logic          wb_ack_i,
  input  logic          wb_err_i,
  output logic          push_o,
  output addr_t         entry_pc_o,
  output word_t         entry_parcel_o,
  output parcel_valid_t entry_valid_o,
  output logic          entry_err_o,
  output logic          entry_misaligned_o
);

  fetch_state_e state;
  addr_t        adr_q;
  logic         misaligned;
  logic         fault;
  logic         bus_done;
  logic         good_read;
  logic         fault_push;
  logic         bus_push;

  assign misaligned = head_pc_i[0];              // Halfword check
  assign fault      = misaligned || pma_fault_i;
  assign bus_done   = wb_ack_i || wb_err_i;
  assign good_read  = (state == BUS) && wb_ack_i && !wb_err_i;

  //////////////////////////////
  // Queue handshakes

  assign fault_push = (state == IDLE) && head_valid_i && fault && !flush_i;
  assign bus_push   = (state == BUS) && bus_done && !flush_i;
  assign push_o     = fault_push || bus_push;
  assign pop_o      = push_o;                    // Head leaves with its entry

  //////////////////////////////
  // Entry contents

  assign entry_pc_o = head_pc_i;
  // Upper half of the word moves down for a PC on bit 1
  assign entry_parcel_o = good_read ? (head_pc_i[1] ? wb_dat_i >> HALF_BITS : wb_dat_i) : '0;
  assign entry_valid_o  = (good_read && head_pc_i[1]) ? VALID_LOW : VALID_BOTH;
  // Misalignment is reported ahead of a region fault
  assign entry_err_o        = (state == IDLE) ? (pma_fault_i && !misaligned) : wb_err_i;
  assign entry_misaligned_o = (state == IDLE) && misaligned;

  //////////////////////////////
  // Sequencer

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (head_valid_i && !fault && room_i && !flush_i) state <= BUS;
        end
        BUS: begin
          if (bus_done) state <= IDLE;
          else if (flush_i) state <= DRAIN;
        end
        DRAIN: begin
          if (bus_done) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Word address, frozen once the read starts
  always_ff @(posedge clk_i) begin
    if (state == IDLE) adr_q <= {head_pc_i[ADDR_W-1:2], 2'b00};
  end

  assign wb_cyc_o = (state != IDLE);
  assign wb_stb_o = (state != IDLE);
  assign wb_adr_o = adr_q;

  // The PC queue head must stay put while its read is on the bus
  a_adr_head: assert property (@(posedge clk_i) disable iff (rst_i)
    state == BUS |-> wb_adr_o == {head_pc_i[ADDR_W-1:2], 2'b00})
    else $error("Wishbone address does not match the head PC");

  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_done |-> wb_cyc_o)
    else $error("Wishbone ack or err outside a cycle");

endmodule

// File: source/imem_parcel_queue.sv
/*
  Eight-entry queue of fetched parcels toward the CPU.
  valid_o reads zero while empty and a pop on an empty queue is ignored.
  almost_full_o throttles new PCs, room_o throttles new bus reads.
*/

`timescale 1ns/100ps

module imem_parcel_queue import imem_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          flush_i,
  input  logic          push_i,
  input  addr_t         pc_i,
  input  word_t         parcel_i,
  input  parcel_valid_t valid_i,
  input  logic          err_i,
  input  logic          misaligned_i,
  input  logic          pop_i,
  output addr_t         pc_o,
  output word_t         parcel_o,
  output parcel_valid_t valid_o,
  output logic          err_o,
  output logic          misaligned_o,
  output logic          almost_full_o,
  output logic          room_o
);

  addr_t               pc_mem     [PARCEL_QUEUE_DEPTH];
  word_t               parcel_mem [PARCEL_QUEUE_DEPTH];
  parcel_valid_t       valid_mem  [PARCEL_QUEUE_DEPTH];
  logic                err_mem    [PARCEL_QUEUE_DEPTH];
  logic                mis_mem    [PARCEL_QUEUE_DEPTH];
  logic [PQ_PTR_W-1:0] wr_ptr;
  logic [PQ_PTR_W-1:0] rd_ptr;
  logic [PQ_CNT_W-1:0] count;
  logic                empty;
  logic                full;
  logic                do_pop;

  assign empty  = (count == '0);
  assign full   = (count == PQ_CNT_W'(PARCEL_QUEUE_DEPTH));
  assign do_pop = pop_i && !empty;

  //////////////////////////////
  // Pointers and fill level

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      pc_mem[wr_ptr]     <= pc_i;
      parcel_mem[wr_ptr] <= parcel_i;
      valid_mem[wr_ptr]  <= valid_i;
      err_mem[wr_ptr]    <= err_i;
      mis_mem[wr_ptr]    <= misaligned_i;
    end
  end

  //////////////////////////////
  // Head and status

  assign pc_o          = pc_mem[rd_ptr];
  assign parcel_o      = parcel_mem[rd_ptr];
  assign valid_o       = empty ? '0 : valid_mem[rd_ptr];
  assign err_o         = err_mem[rd_ptr];
  assign misaligned_o  = mis_mem[rd_ptr];
  assign almost_full_o = (count >= PQ_CNT_W'(PARCEL_ALMOST_FULL));
  assign room_o        = (count < PQ_CNT_W'(PARCEL_ROOM_LIMIT));

  // The PC throttle and room limit together must keep this from overflowing
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i && !flush_i |-> !full)
    else $error("Parcel queue push while full");

endmodule

// File: source/imem_ctrl.sv
/*
  Instruction fetch controller with a Wishbone classic master port.
  Chain is PC queue, alignment and PMA checks, bus fetch, parcel queue.
  Read only, word aligned, one outstanding read.
*/

`timescale 1ns/100ps

module imem_ctrl import imem_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_i,
  input  addr_t               nxt_pc_i,
  input  logic                nxt_pc_valid_i,
  output logic                stall_nxt_pc_o,
  input  logic                stall_i,
  input  logic                flush_i,
  input  addr_t [PMA_CNT-1:0] pma_limit_i,
  input  logic  [PMA_CNT-1:0] pma_exec_i,
  output addr_t               parcel_pc_o,
  output word_t               parcel_o,
  output parcel_valid_t       parcel_valid_o,
  output logic                err_o,
  output logic                misaligned_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output addr_t               wb_adr_o,
  input  word_t               wb_dat_i,
  input  logic                wb_ack_i,
  input  logic                wb_err_i
);

  logic          pc_push;
  logic          pc_pop;
  logic          pc_full;
  logic          head_valid;
  addr_t         head_pc;
  logic          pma_fault;
  logic          pq_push;
  logic          pq_pop;
  logic          pq_almost_full;
  logic          pq_room;
  addr_t         entry_pc;
  word_t         entry_parcel;
  parcel_valid_t entry_valid;
  logic          entry_err;
  logic          entry_misaligned;

  //////////////////////////////
  // Accept and consume

  assign stall_nxt_pc_o = pc_full || pq_almost_full;
  assign pc_push        = nxt_pc_valid_i && !stall_nxt_pc_o;
  assign pq_pop         = (|parcel_valid_o) && !stall_i;   // CPU takes the head

  imem_pc_queue pc_queue_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .push_i       (pc_push),
    .pc_i         (nxt_pc_i),
    .pop_i        (pc_pop),
    .head_valid_o (head_valid),
    .head_pc_o    (head_pc),
    .full_o       (pc_full)
  );

  imem_pma_check pma_check_inst (
    .pc_i        (head_pc),
    .pma_limit_i (pma_limit_i),
    .pma_exec_i  (pma_exec_i),
    .fault_o     (pma_fault)
  );

  imem_wb_fetch wb_fetch_inst (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .flush_i            (flush_i),
    .head_valid_i       (head_valid),
    .head_pc_i          (head_pc),
    .pma_fault_i        (pma_fault),
    .room_i             (pq_room),
    .pop_o              (pc_pop),
    .wb_cyc_o           (wb_cyc_o),
    .wb_stb_o           (wb_stb_o),
    .wb_adr_o           (wb_adr_o),
    .wb_dat_i           (wb_dat_i),
    .wb_ack_i           (wb_ack_i),
    .wb_err_i           (wb_err_i),
    .push_o             (pq_push),
    .entry_pc_o         (entry_pc),
    .entry_parcel_o     (entry_parcel),
    .entry_valid_o      (entry_valid),
    .entry_err_o        (entry_err),
    .entry_misaligned_o (entry_misaligned)
  );

  imem_parcel_queue parcel_queue_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .flush_i       (flush_i),
    .push_i        (pq_push),
    .pc_i          (entry_pc),
    .parcel_i      (entry_parcel),
    .valid_i       (entry_valid),
    .err_i         (entry_err),
    .misaligned_i  (entry_misaligned),
    .pop_i         (pq_pop),
    .pc_o          (parcel_pc_o),
    .parcel_o      (parcel_o),
    .valid_o       (parcel_valid_o),
    .err_o         (err_o),
    .misaligned_o  (misaligned_o),
    .almost_full_o (pq_almost_full),
    .room_o        (pq_room)
  );

endmodule

// File: tests/imem_wb_memory.sv
/*
  Wishbone classic slave model for the fetch tests.
  Read data is the word address XOR 0xA5A5_0000. Addresses inside the
  error window answer with err. Each access sees 0 to 3 random wait states.
*/

`timescale 1ns/100ps

module imem_wb_memory import imem_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  addr_t adr_i,
  output word_t dat_o,
  output logic  ack_o,
  output logic  err_o
);

  localparam word_t DATA_KEY  = 32'hA5A5_0000;
  localparam addr_t ERR_BASE  = 32'h0000_3000;
  localparam addr_t ERR_LIMIT = 32'h0000_3040;   // Exclusive

  logic [1:0] wait_left;   // Wait states before the next answer
  logic       respond;
  logic       in_err;

  assign respond = cyc_i && stb_i && (wait_left == 2'd0);
  assign in_err  = (adr_i >= ERR_BASE) && (adr_i < ERR_LIMIT);
  assign ack_o   = respond && !in_err;
  assign err_o   = respond && in_err;
  assign dat_o   = ack_o ? (adr_i ^ DATA_KEY) : '0;

  // Wait count of the next access is drawn as the current one ends
  always_ff @(posedge clk_i) begin
    if (rst_i || respond) begin
      wait_left <= 2'($urandom % 4);
    end else if (cyc_i && stb_i) begin
      wait_left <= wait_left - 2'd1;
    end
  end

endmodule

// File: tests/imem_tb.sv
/*
  Testbench for the instruction fetch controller.
  Rows are offered in order; a hold row keeps the CPU stalled for a while,
  a flush row drops every pending entry. Outputs are sampled at each edge.
*/

`timescale 1ns/100ps

module imem_tb import imem_pkg::*;;

  localparam int CLK_PERIOD     = 10;
  localparam int SEED           = 96446;
  localparam int HOLD_MAX       = 20;   // Stall cycles per hold row
  localparam int CYCLES_PER_ROW = 40;

  typedef struct packed {
    addr_t         pc;
    logic          flush;
    logic          hold;
    logic          bus;     // A bus read is allowed for this PC
    word_t         parcel;
    parcel_valid_t valid;
    logic          err;
    logic          mis;
  } row_t;

  logic                clk_i = 1'b0;
  logic                rst_i;
  addr_t               nxt_pc_i;
  logic                nxt_pc_valid_i;
  logic                stall_nxt_pc_o;
  logic                stall_i;
  logic                flush_i;
  addr_t [PMA_CNT-1:0] pma_limit;
  logic  [PMA_CNT-1:0] pma_exec;
  addr_t               parcel_pc_o;
  word_t               parcel_o;
  parcel_valid_t       parcel_valid_o;
  logic                err_o;
  logic                misaligned_o;
  logic                wb_cyc_o;
  logic                wb_stb_o;
  addr_t               wb_adr_o;
  word_t               wb_dat_i;
  logic                wb_ack_i;
  logic                wb_err_i;

  row_t  rows[$];
  int    exp_q[$];      // Accepted rows still waiting for their entry
  int    next_row     = 0;
  int    hold_cnt     = 0;
  int    errors       = 0;
  int    row_err      = 0;
  int    checked      = 0;
  int    discarded    = 0;
  int    failed_rows  = 0;
  logic  cyc_q        = 1'b0;
  logic  done_q       = 1'b0;
  addr_t bus_adr_q    = '0;
  logic  saw_pc_stall = 1'b0;
  bit    table_ready  = 1'b0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  imem_ctrl imem_ctrl_inst (
    .clk_i (clk_i), .rst_i (rst_i),
    .nxt_pc_i (nxt_pc_i), .nxt_pc_valid_i (nxt_pc_valid_i), .stall_nxt_pc_o (stall_nxt_pc_o),
    .stall_i (stall_i), .flush_i (flush_i),
    .pma_limit_i (pma_limit), .pma_exec_i (pma_exec),
    .parcel_pc_o (parcel_pc_o), .parcel_o (parcel_o), .parcel_valid_o (parcel_valid_o),
    .err_o (err_o), .misaligned_o (misaligned_o),
    .wb_cyc_o (wb_cyc_o), .wb_stb_o (wb_stb_o), .wb_adr_o (wb_adr_o),
    .wb_dat_i (wb_dat_i), .wb_ack_i (wb_ack_i), .wb_err_i (wb_err_i)
  );

  imem_wb_memory memory_inst (
    .clk_i (clk_i), .rst_i (rst_i), .cyc_i (wb_cyc_o), .stb_i (wb_stb_o),
    .adr_i (wb_adr_o), .dat_o (wb_dat_i), .ack_o (wb_ack_i), .err_o (wb_err_i)
  );

  task automatic add_row(input addr_t pc, input logic flush, input logic hold,
                         input logic bus, input word_t parcel, input parcel_valid_t valid,
                         input logic err, input logic mis);
    rows.push_back({pc, flush, hold, bus, parcel, valid, err, mis});
  endtask

  //////////////////////////////
  // Stimulus and expected values
  // Regions: <0x1000 exec, <0x2000 no exec, <0x1_0000 exec, <0x8000_0000 exec
  task automatic load_table();
    //       pc             fl hd bus parcel         valid  err mis
    add_row(32'h0000_0100, 0, 0, 1, 32'hA5A5_0100, 2'b11, 0, 0);
    add_row(32'h0000_0104, 0, 0, 1, 32'hA5A5_0104, 2'b11, 0, 0);
    add_row(32'h0000_8ABC, 0, 0, 1, 32'hA5A5_8ABC, 2'b11, 0, 0);
    add_row(32'h1234_5672, 0, 0, 1, 32'h0000_B791, 2'b01, 0, 0);   // Upper half moves down
    add_row(32'h0000_0FFE, 0, 0, 1, 32'h0000_A5A5, 2'b01, 0, 0);
    add_row(32'h0000_0201, 0, 0, 0, 32'h0000_0000, 2'b11, 0, 1);
    add_row(32'h0000_0303, 0, 0, 0, 32'h0000_0000, 2'b11, 0, 1);
    add_row(32'h0000_1800, 0, 0, 0, 32'h0000_0000, 2'b11, 1, 0);   // Not executable
    add_row(32'h9000_0000, 0, 0, 0, 32'h0000_0000, 2'b11, 1, 0);   // Above all limits
    add_row(32'h0000_1FFE, 0, 0, 0, 32'h0000_0000, 2'b11, 1, 0);
    add_row(32'h0000_3010, 0, 0, 1, 32'h0000_0000, 2'b11, 1, 0);   // Slave error window
    add_row(32'h0000_3022, 0, 0, 1, 32'h0000_0000, 2'b11, 1, 0);
    add_row(32'h0000_0500, 0, 1, 1, 32'hA5A5_0500, 2'b11, 0, 0);
    add_row(32'h0000_0504, 0, 1, 1, 32'hA5A5_0504, 2'b11, 0, 0);
    add_row(32'h0000_0000, 1, 0, 1, 32'h0000_0000, 2'b11, 0, 0);   // Flush
    add_row(32'h0000_0600, 0, 0, 1, 32'hA5A5_0600, 2'b11, 0, 0);
    add_row(32'h0000_0602, 0, 0, 1, 32'h0000_A5A5, 2'b01, 0, 0);
    for (int i = 0; i < 8; i++) begin   // Long stall fills the parcel queue
      add_row(32'h0000_0700 + 4 * i, 0, 1, 1, 32'hA5A5_0700 + 4 * i, 2'b11, 0, 0);
    end
    add_row(32'h0001_0000, 0, 0, 1, 32'hA5A4_0000, 2'b11, 0, 0);
  endtask

  //////////////////////////////
  // Compare tasks
  task automatic report(input string msg);
    errors++;
    row_err++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic check_pc(input addr_t got, input addr_t want);
    if (got !== want) report($sformatf("pc is %h, expected %h", got, want));
  endtask

  task automatic check_parcel(input word_t got, input word_t want);
    if (got !== want) report($sformatf("parcel is %h, expected %h", got, want));
  endtask

  task automatic check_valid(input parcel_valid_t got, input parcel_valid_t want);
    if (got !== want) report($sformatf("valid is %b, expected %b", got, want));
  endtask

  task automatic check_flags(input logic got_err, input logic got_mis,
                             input logic want_err, input logic want_mis);
    if (got_err !== want_err || got_mis !== want_mis) begin
      report($sformatf("err/misaligned are %b/%b, expected %b/%b",
                       got_err, got_mis, want_err, want_mis));
    end
  endtask

  // Fault PCs must never reach the bus
  task automatic check_bus_start(input addr_t adr);
    foreach (rows[i]) begin
      if (!rows[i].bus && !rows[i].flush && {rows[i].pc[ADDR_W-1:2], 2'b00} == adr) begin
        report($sformatf("bus read started for fault pc %h", rows[i].pc));
      end
    end
  endtask

  task automatic consume_head();
    int   idx;
    row_t r;
    if (exp_q.size() == 0) begin
      report($sformatf("entry for pc %h appeared with no PC pending", parcel_pc_o));
    end else begin
      idx = exp_q.pop_front();
      r = rows[idx];
      row_err = 0;
      check_pc(parcel_pc_o, r.pc);
      check_parcel(parcel_o, r.parcel);
      check_valid(parcel_valid_o, r.valid);
      check_flags(err_o, misaligned_o, r.err, r.mis);
      checked++;
      if (row_err != 0) failed_rows++;
      $display("row %0d pc %h %s", idx, r.pc, (row_err == 0) ? "ok" : "mismatch");
    end
  endtask

  // Called right after an edge, so it sees the values that edge sampled
  task automatic observe_edge();
    int idx;
    // Wishbone classic master rules
    if (wb_stb_o !== wb_cyc_o) report("wb_stb_o does not match wb_cyc_o");
    if (wb_cyc_o && wb_adr_o[1:0] !== 2'b00) begin
      report($sformatf("bus address %h is not word aligned", wb_adr_o));
    end
    if (cyc_q && !done_q && !wb_cyc_o) report("wb_cyc_o dropped before ack or err");
    if (cyc_q && done_q && wb_cyc_o) report("wb_cyc_o stayed high after ack or err");
    if (cyc_q && !done_q && wb_cyc_o && wb_adr_o !== bus_adr_q) begin
      report($sformatf("bus address moved from %h to %h during a read",
                       bus_adr_q, wb_adr_o));
    end
    if (wb_cyc_o && !cyc_q) check_bus_start(wb_adr_o);
    cyc_q     = wb_cyc_o;
    done_q    = wb_ack_i || wb_err_i;
    bus_adr_q = wb_adr_o;
    if (nxt_pc_valid_i && stall_nxt_pc_o) saw_pc_stall = 1'b1;
    if (flush_i) begin
      while (exp_q.size() != 0) begin
        idx = exp_q.pop_front();
        discarded++;
        $display("row %0d pc %h discarded by flush", idx, rows[idx].pc);
      end
      $display("row %0d flush", next_row);
      next_row++;
    end else begin
      // An accepted PC finds at most one queued PC and an unthrottled parcel queue
      if (nxt_pc_valid_i && !stall_nxt_pc_o &&
          exp_q.size() > PARCEL_ALMOST_FULL + PC_QUEUE_DEPTH - 2) begin
        report($sformatf("PC accepted with %0d entries outstanding", exp_q.size()));
      end
      if ((|parcel_valid_o) && !stall_i) consume_head();
      if (nxt_pc_valid_i && !stall_nxt_pc_o) begin
        exp_q.push_back(next_row);
        next_row++;
        hold_cnt = 0;
      end
    end
  endtask

  task automatic drive_inputs();
    logic hold;
    hold = 1'b0;
    if (next_row < rows.size() && rows[next_row].flush) begin
      flush_i        <= 1'b1;
      nxt_pc_valid_i <= 1'b0;
      stall_i        <= 1'b1;   // Nothing consumed on the flush edge
    end else begin
      flush_i <= 1'b0;
      if (next_row < rows.size()) begin
        nxt_pc_valid_i <= 1'b1;
        nxt_pc_i       <= rows[next_row].pc;
        hold = rows[next_row].hold && (hold_cnt < HOLD_MAX);
      end else begin
        nxt_pc_valid_i <= 1'b0;
      end
      if (hold) begin
        stall_i <= 1'b1;
        hold_cnt++;
      end else begin
        stall_i <= (($urandom % 4) == 0);
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  initial begin : main
    void'($urandom(SEED));
    load_table();
    table_ready = 1'b1;
    pma_limit      <= {32'h8000_0000, 32'h0001_0000, 32'h0000_2000, 32'h0000_1000};
    pma_exec       <= 4'b1101;
    rst_i          <= 1'b1;
    nxt_pc_i       <= '0;
    nxt_pc_valid_i <= 1'b0;
    stall_i        <= 1'b0;
    flush_i        <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    if (wb_cyc_o || wb_stb_o || stall_nxt_pc_o || (|parcel_valid_o)) begin
      report("outputs are not idle during reset");
    end
    while (next_row < rows.size() || exp_q.size() != 0) begin
      @(posedge clk_i);
      observe_edge();
      drive_inputs();
    end
    repeat (10) begin   // Nothing more may appear
      @(posedge clk_i);
      observe_edge();
      drive_inputs();
    end
    if (!saw_pc_stall) report("stall_nxt_pc_o never rose during the long stall");
    $display("Summary: %0d rows, %0d checked, %0d discarded, %0d failed rows, %0d errors",
             rows.size(), checked, discarded, failed_rows, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (table_ready);
    #((rows.size() * CYCLES_PER_ROW + 100) * CLK_PERIOD);
    $display("Timeout: not every accepted PC came back before the time limit");
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: build.f
source/imem_pkg.sv
source/imem_pc_queue.sv
source/imem_pma_check.sv
source/imem_wb_fetch.sv
source/imem_parcel_queue.sv
source/imem_ctrl.sv
tests/imem_wb_memory.sv
tests/imem_tb.sv

// File: Bender.yml
package:
  name: imem_ctrl

sources:
  - files:
      - source/imem_pkg.sv
      - source/imem_pc_queue.sv
      - source/imem_pma_check.sv
      - source/imem_wb_fetch.sv
      - source/imem_parcel_queue.sv
      - source/imem_ctrl.sv
  - target: test
    files:
      - tests/imem_wb_memory.sv
      - tests/imem_tb.sv
